// ==== vtp_pkg.sv ====
// Shared definitions for the virtual-to-physical page translation service
// Widths of addresses and tags, TLB geometry, FIFO sizing, walk latency
// and the page walker state encoding
`default_nettype none

package vtp_pkg;

    // ====================
    // Widths
    // ====================

    // Virtual and physical page numbers
    typedef logic [7:0]  vpn_t;
    typedef logic [11:0] ppn_t;

    // Tag that clients attach to a request and get back with the response
    typedef logic [3:0]  tag_t;

    // The low VPN bits select the TLB entry and the high bits are the key
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [3:0]  tlb_key_t;

    // A queued request is a VPN with its tag
    localparam int REQ_BITS = $bits(vpn_t) + $bits(tag_t);

    // ====================
    // Sizes and latency
    // ====================

    localparam int TLB_ENTRIES = 16;
    localparam int PT_ENTRIES = 2 ** $bits(vpn_t);

    // Modeled page-table memory latency, in cycles
    localparam int WALK_CYCLES = 6;

    // The active FIFO must always keep room to put a missed lookup back
    localparam int ACTIVE_DEPTH = 16;
    localparam int ACTIVE_THRESHOLD = 3;
    localparam int IN_DEPTH = 2;

    // Page walker states
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_WAIT,
        WALK_READ,
        WALK_FILL
    } walk_state_t;

endpackage

`default_nettype wire

// ==== vtp_ifs.sv ====
// Internal buses of the translation service
// vtp_tlb_if carries lookups from the pipeline to the TLB and the answers back,
// vtp_walk_if carries walk requests from the TLB and fills from the walker
`timescale 1ns/100ps
`default_nettype none

interface vtp_tlb_if import vtp_pkg::*;
();
    // Lookup issued by the pipeline
    logic lookup_en;
    vpn_t lookup_vpn;
    tag_t lookup_tag;

    // Answer one cycle after lookup_en, either a hit or a miss
    logic rsp_valid;
    logic rsp_miss;
    ppn_t rsp_ppn;
    logic rsp_fault;

    modport pipe (
        output lookup_en, lookup_vpn, lookup_tag,
        input  rsp_valid, rsp_miss, rsp_ppn, rsp_fault
    );

    modport tlb (
        input  lookup_en, lookup_vpn, lookup_tag,
        output rsp_valid, rsp_miss, rsp_ppn, rsp_fault
    );
endinterface

interface vtp_walk_if import vtp_pkg::*;
();
    // Walk request, only raised while the walker is idle
    logic walk_start;
    vpn_t walk_vpn;

    // Walker status and the strobe that writes one TLB entry
    logic walk_busy;
    logic fill_en;
    vpn_t fill_vpn;
    ppn_t fill_ppn;
    logic fill_fault;

    modport tlb (
        output walk_start, walk_vpn,
        input  walk_busy, fill_en, fill_vpn, fill_ppn, fill_fault
    );

    modport walker (
        input  walk_start, walk_vpn,
        output walk_busy, fill_en, fill_vpn, fill_ppn, fill_fault
    );
endinterface

`default_nettype wire

// ==== vtp_fifo.sv ====
// Synchronous FIFO built on a circular buffer
// The oldest entry is always visible on first, and almost_full rises
// when the free space drops to the shared threshold
`timescale 1ns/100ps
`default_nettype none

module vtp_fifo import vtp_pkg::*;
#(
    parameter int DEPTH = 2,
    parameter int WIDTH = 8
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             enq_en,
    input  logic [WIDTH-1:0] enq_data,
    input  logic             deq_en,
    output logic [WIDTH-1:0] first,
    output logic             not_empty,
    output logic             not_full,
    output logic             almost_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (deq_en)
                rd_ptr <= next_ptr(rd_ptr);
            // Simultaneous enqueue and dequeue leave the count unchanged
            count <= count + CNT_W'(enq_en) - CNT_W'(deq_en);
        end
    end

    // Storage holds payload only
    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full = (count != CNT_W'(DEPTH));

    // Signed compare so a FIFO shallower than the threshold reads as always near full
    assign almost_full = (int'(count) + ACTIVE_THRESHOLD >= DEPTH);

endmodule

`default_nettype wire

// ==== vtp_walk_timer.sv ====
// Walk latency timer
// A down-counter that pulses done WALK_CYCLES cycles after load
`timescale 1ns/100ps
`default_nettype none

module vtp_walk_timer import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic load,
    output logic done
);
    localparam int CNT_W = $clog2(WALK_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (load)
        begin
            count <= CNT_W'(WALK_CYCLES);
        end
        else if (count != '0)
        begin
            // Parks at zero until the next load
            count <= count - 1'b1;
        end
    end

    assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// ==== vtp_page_table.sv ====
// Page-table memory
// One entry per VPN holding a PPN and a valid bit. Written during setup,
// read by the walker with one cycle of latency
`timescale 1ns/100ps
`default_nettype none

module vtp_page_table import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic wr_en,
    input  vpn_t wr_vpn,
    input  ppn_t wr_ppn,
    input  logic wr_valid,
    input  logic rd_en,
    input  vpn_t rd_vpn,
    output ppn_t rd_ppn,
    output logic rd_valid
);
    logic [PT_ENTRIES-1:0] pt_valid;
    ppn_t pt_ppn [PT_ENTRIES];

    // Nothing is mapped after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_valid <= '0;
        end
        else if (wr_en)
        begin
            pt_valid[wr_vpn] <= wr_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            pt_ppn[wr_vpn] <= wr_ppn;

        // Registered read port
        if (rd_en)
        begin
            rd_ppn <= pt_ppn[rd_vpn];
            rd_valid <= pt_valid[rd_vpn];
        end
    end

endmodule

`default_nettype wire

// ==== vtp_walker.sv ====
// Page walker FSM
// Latches the VPN on walk_start, waits out the modeled memory latency,
// reads the page table and writes the result into the TLB
`timescale 1ns/100ps
`default_nettype none

module vtp_walker import vtp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    vtp_walk_if.walker walk,
    output logic       timer_load,
    input  logic       timer_done,
    output logic       pt_rd_en,
    output vpn_t       pt_rd_vpn,
    input  ppn_t       pt_rd_ppn,
    input  logic       pt_rd_valid
);
    walk_state_t state;
    vpn_t walk_vpn_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= WALK_IDLE;
        end
        else
        begin
            case (state)
                WALK_IDLE:
                    if (walk.walk_start)
                        state <= WALK_WAIT;
                // Timer was loaded together with the start strobe
                WALK_WAIT:
                    if (timer_done)
                        state <= WALK_READ;
                WALK_READ:
                    state <= WALK_FILL;
                default:
                    state <= WALK_IDLE;
            endcase
        end

        if (state == WALK_IDLE && walk.walk_start)
            walk_vpn_q <= walk.walk_vpn;
    end

    assign walk.walk_busy = (state != WALK_IDLE);
    assign timer_load = (state == WALK_IDLE) && walk.walk_start;

    // Read data arrives during WALK_FILL
    assign pt_rd_en = (state == WALK_READ);
    assign pt_rd_vpn = walk_vpn_q;

    // An unmapped page is cached as a fault with a zero PPN
    assign walk.fill_en = (state == WALK_FILL);
    assign walk.fill_vpn = walk_vpn_q;
    assign walk.fill_ppn = pt_rd_valid ? pt_rd_ppn : '0;
    assign walk.fill_fault = !pt_rd_valid;

endmodule

`default_nettype wire

// ==== vtp_tlb.sv ====
// Direct-mapped TLB with 16 entries
// A lookup is compared against the indexed entry one cycle after lookup_en
// and answered as a hit or a miss. A miss while the walker is idle
// launches a page walk, and the walker's fill overwrites the entry
`timescale 1ns/100ps
`default_nettype none

module vtp_tlb import vtp_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    vtp_tlb_if.tlb  tlb,
    vtp_walk_if.tlb walk
);
    // Entry storage, only the valid bits are control state
    logic [TLB_ENTRIES-1:0] tlb_valid;
    logic [TLB_ENTRIES-1:0] tlb_fault;
    tlb_key_t tlb_key [TLB_ENTRIES];
    ppn_t tlb_ppn [TLB_ENTRIES];

    // Lookup stage registers
    logic lk_pend;
    vpn_t lk_vpn;
    tlb_idx_t lk_idx;
    tlb_key_t lk_key;
    logic lk_hit;
    logic lk_miss;

    tlb_idx_t fill_idx;
    tlb_key_t fill_key;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lk_pend <= 1'b0;
        end
        else
        begin
            lk_pend <= tlb.lookup_en;
        end

        lk_vpn <= tlb.lookup_vpn;
    end

    // ====================
    // Compare
    // ====================

    assign lk_idx = lk_vpn[$bits(tlb_idx_t)-1:0];
    assign lk_key = lk_vpn[$bits(vpn_t)-1 -: $bits(tlb_key_t)];
    assign lk_hit = tlb_valid[lk_idx] && (tlb_key[lk_idx] == lk_key);
    assign lk_miss = lk_pend && !lk_hit;

    assign tlb.rsp_valid = lk_pend && lk_hit;
    assign tlb.rsp_miss = lk_miss;
    assign tlb.rsp_ppn = tlb_ppn[lk_idx];
    assign tlb.rsp_fault = tlb_fault[lk_idx];

    // Misses during a walk are simply retried by the pipeline later
    assign walk.walk_start = lk_miss && !walk.walk_busy;
    assign walk.walk_vpn = lk_vpn;

    // ====================
    // Fill
    // ====================

    assign fill_idx = walk.fill_vpn[$bits(tlb_idx_t)-1:0];
    assign fill_key = walk.fill_vpn[$bits(vpn_t)-1 -: $bits(tlb_key_t)];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tlb_valid <= '0;
        end
        else if (walk.fill_en)
        begin
            tlb_valid[fill_idx] <= 1'b1;
        end
    end

    // Whatever mapped to the same index is evicted
    always_ff @(posedge clk)
    begin
        if (walk.fill_en)
        begin
            tlb_key[fill_idx] <= fill_key;
            tlb_ppn[fill_idx] <= walk.fill_ppn;
            tlb_fault[fill_idx] <= walk.fill_fault;
        end
    end

endmodule

`default_nettype wire

// ==== vtp_pipe.sv ====
// Translation pipeline
// Requests are queued, looked up in the TLB and tracked in an active FIFO
// until the TLB answers. A miss sends the oldest active lookup straight
// back into the lookup stream, so hits behind it keep returning while the
// walker fills the TLB. Responses leave in order of TLB success
`timescale 1ns/100ps
`default_nettype none

module vtp_pipe import vtp_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req_en,
    input  vpn_t    req_vpn,
    input  tag_t    req_tag,
    output logic    req_rdy,
    output logic    rsp_valid,
    output tag_t    rsp_tag,
    output ppn_t    rsp_ppn,
    output logic    rsp_fault,
    vtp_tlb_if.pipe tlb
);

    // ====================
    // Input queue
    // ====================

    logic [REQ_BITS-1:0] new_req;
    vpn_t new_vpn;
    tag_t new_tag;
    logic new_req_rdy;
    logic new_req_deq;
    logic in_enq;
    logic in_not_full;

    vtp_fifo #(
        .DEPTH(IN_DEPTH),
        .WIDTH(REQ_BITS)
    ) in_fifo (
        .clk(clk),
        .reset(reset),
        .enq_en(in_enq),
        .enq_data({req_vpn, req_tag}),
        .deq_en(new_req_deq),
        .first(new_req),
        .not_empty(new_req_rdy),
        .not_full(in_not_full),
        .almost_full()
    );

    assign {new_vpn, new_tag} = new_req;

    // ====================
    // Active lookups
    // ====================

    logic lookup_en;
    vpn_t lookup_vpn;
    tag_t lookup_tag;
    logic [REQ_BITS-1:0] active_head;
    vpn_t head_vpn;
    tag_t head_tag;
    logic active_almost_full;

    // Every lookup in flight sits here, and the TLB answers them in order,
    // so the head always belongs to the answer of the current cycle
    vtp_fifo #(
        .DEPTH(ACTIVE_DEPTH),
        .WIDTH(REQ_BITS)
    ) active_reqs (
        .clk(clk),
        .reset(reset),
        .enq_en(lookup_en),
        .enq_data({lookup_vpn, lookup_tag}),
        .deq_en(tlb.rsp_valid || tlb.rsp_miss),
        .first(active_head),
        .not_empty(),
        .not_full(),
        .almost_full(active_almost_full)
    );

    assign {head_vpn, head_tag} = active_head;

    // Accept from the client only while both queues have room
    assign req_rdy = in_not_full && !active_almost_full;
    assign in_enq = req_en && req_rdy;

    // A retry owns the lookup register, so a new request waits a cycle
    assign new_req_deq = new_req_rdy && !active_almost_full && !tlb.rsp_miss;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_en <= 1'b0;
        end
        else
        begin
            lookup_en <= tlb.rsp_miss || new_req_deq;
        end

        // The next lookup is either the missed head or the new request
        lookup_vpn <= tlb.rsp_miss ? head_vpn : new_vpn;
        lookup_tag <= tlb.rsp_miss ? head_tag : new_tag;
    end

    assign tlb.lookup_en = lookup_en;
    assign tlb.lookup_vpn = lookup_vpn;
    assign tlb.lookup_tag = lookup_tag;

    // ====================
    // Responses
    // ====================

    // A hit is registered with the tag of the head it answers
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= tlb.rsp_valid;
        end

        rsp_tag <= head_tag;
        rsp_ppn <= tlb.rsp_ppn;
        rsp_fault <= tlb.rsp_fault;
    end

endmodule

`default_nettype wire

// ==== vtp_top.sv ====
// Top level of the page translation service
// Connects the pipeline, TLB, walker, walk timer and page-table memory
`timescale 1ns/100ps
`default_nettype none

module vtp_top import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic pt_wr_en,
    input  vpn_t pt_wr_vpn,
    input  ppn_t pt_wr_ppn,
    input  logic pt_wr_valid,
    input  logic req_en,
    input  vpn_t req_vpn,
    input  tag_t req_tag,
    output logic req_rdy,
    output logic rsp_valid,
    output tag_t rsp_tag,
    output ppn_t rsp_ppn,
    output logic rsp_fault
);
    vtp_tlb_if tlb_bus ();
    vtp_walk_if walk_bus ();

    // Walker side wires
    logic timer_load;
    logic timer_done;
    logic pt_rd_en;
    vpn_t pt_rd_vpn;
    ppn_t pt_rd_ppn;
    logic pt_rd_valid;

    vtp_pipe pipe0 (
        .clk(clk),
        .reset(reset),
        .req_en(req_en),
        .req_vpn(req_vpn),
        .req_tag(req_tag),
        .req_rdy(req_rdy),
        .rsp_valid(rsp_valid),
        .rsp_tag(rsp_tag),
        .rsp_ppn(rsp_ppn),
        .rsp_fault(rsp_fault),
        .tlb(tlb_bus.pipe)
    );

    vtp_tlb tlb0 (
        .clk(clk),
        .reset(reset),
        .tlb(tlb_bus.tlb),
        .walk(walk_bus.tlb)
    );

    vtp_walker walker0 (
        .clk(clk),
        .reset(reset),
        .walk(walk_bus.walker),
        .timer_load(timer_load),
        .timer_done(timer_done),
        .pt_rd_en(pt_rd_en),
        .pt_rd_vpn(pt_rd_vpn),
        .pt_rd_ppn(pt_rd_ppn),
        .pt_rd_valid(pt_rd_valid)
    );

    vtp_walk_timer timer0 (
        .clk(clk),
        .reset(reset),
        .load(timer_load),
        .done(timer_done)
    );

    vtp_page_table pt0 (
        .clk(clk),
        .reset(reset),
        .wr_en(pt_wr_en),
        .wr_vpn(pt_wr_vpn),
        .wr_ppn(pt_wr_ppn),
        .wr_valid(pt_wr_valid),
        .rd_en(pt_rd_en),
        .rd_vpn(pt_rd_vpn),
        .rd_ppn(pt_rd_ppn),
        .rd_valid(pt_rd_valid)
    );

endmodule

`default_nettype wire

// ==== vtp_asserts.sv ====
// Protocol checks for the translation pipeline and the TLB
// Bound into vtp_tlb, which sees the lookup bus driven by the pipeline
// and the walker bus in the same place
`timescale 1ns/100ps
`default_nettype none

module vtp_asserts
(
    input logic clk,
    input logic reset,
    input logic rsp_valid,
    input logic rsp_miss,
    input logic lookup_en,
    input logic fill_en,
    input logic walk_start
);

    // The TLB answers each lookup either as a hit or as a miss, never both
    hit_or_miss_only: assert property (@(posedge clk) disable iff (reset)
        !(rsp_valid && rsp_miss))
        else $error("TLB raised rsp_valid and rsp_miss in the same cycle");

    // A missed lookup goes straight back into the lookup register
    miss_reissued: assert property (@(posedge clk) disable iff (reset)
        rsp_miss |=> lookup_en)
        else $error("missed lookup was not reissued on the next cycle");

    // Walks only start while the walker is idle, and a fill means it is busy
    fill_apart_from_start: assert property (@(posedge clk) disable iff (reset)
        !(fill_en && walk_start))
        else $error("TLB fill and walk start in the same cycle");

endmodule

bind vtp_tlb vtp_asserts tlb_checks (
    .clk(clk),
    .reset(reset),
    .rsp_valid(tlb.rsp_valid),
    .rsp_miss(tlb.rsp_miss),
    .lookup_en(tlb.lookup_en),
    .fill_en(walk.fill_en),
    .walk_start(walk.walk_start)
);

`default_nettype wire

// ==== vtp_tb.sv ====
// Testbench for the page translation service
// Loads page-table writes and lookups from the test file, issues the
// lookups with random gaps under req_rdy and scoreboards responses by tag
`timescale 1ns/100ps
`default_nettype none

module vtp_tb import vtp_pkg::*;
();
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;
    localparam int TB_GAP_MAX = 3;
    localparam int TAGS = 2 ** $bits(tag_t);

    logic clk;
    logic reset;
    logic pt_wr_en;
    vpn_t pt_wr_vpn;
    ppn_t pt_wr_ppn;
    logic pt_wr_valid;
    logic req_en;
    vpn_t req_vpn;
    tag_t req_tag;
    logic req_rdy;
    logic rsp_valid;
    tag_t rsp_tag;
    ppn_t rsp_ppn;
    logic rsp_fault;

    // Test records in file order, unused fields hold zero
    byte op_kind [$];
    int op_a [$];
    int op_b [$];
    int op_c [$];
    int op_d [$];

    // Scoreboard, a tag is outstanding while its two counts differ
    ppn_t exp_ppn [TAGS];
    logic exp_fault [TAGS];
    int issue_cnt [TAGS] = '{default: 0};
    int return_cnt [TAGS] = '{default: 0};
    int issued_total = 0;
    int returned_total = 0;
    int lookup_count = 0;
    int watchdog_cycles = 0;
    integer seed = 32'hccf8_3bec;

    vtp_top dut0 (
        .clk(clk),
        .reset(reset),
        .pt_wr_en(pt_wr_en),
        .pt_wr_vpn(pt_wr_vpn),
        .pt_wr_ppn(pt_wr_ppn),
        .pt_wr_valid(pt_wr_valid),
        .req_en(req_en),
        .req_vpn(req_vpn),
        .req_tag(req_tag),
        .req_rdy(req_rdy),
        .rsp_valid(rsp_valid),
        .rsp_tag(rsp_tag),
        .rsp_ppn(rsp_ppn),
        .rsp_fault(rsp_fault)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // ====================
    // Test file
    // ====================

    task automatic load_tests();
        int fd;
        int c;
        int n;
        int a;
        int b;
        int d;
        int e;
        byte ch;
        fd = $fopen("vtp_tests.txt", "r");
        if (fd == 0)
            fail_run("could not open vtp_tests.txt for reading");
        c = $fgetc(fd);
        while (c != -1)
        begin
            ch = byte'(c);
            a = 0;
            b = 0;
            d = 0;
            e = 0;
            if (ch == "#")
            begin
                // Comments run to the end of the line
                while (c != -1 && byte'(c) != "\n")
                    c = $fgetc(fd);
            end
            else if (ch == "W" || ch == "L" || ch == "P")
            begin
                if (ch == "W")
                begin
                    n = $fscanf(fd, "%h %h %h", a, b, d);
                    if (n != 3)
                        fail_run("page-table write record in vtp_tests.txt is incomplete");
                end
                else if (ch == "L")
                begin
                    n = $fscanf(fd, "%h %h %h %h", a, b, d, e);
                    if (n != 4)
                        fail_run("lookup record in vtp_tests.txt is incomplete");
                    lookup_count++;
                end
                op_kind.push_back(ch);
                op_a.push_back(a);
                op_b.push_back(b);
                op_c.push_back(d);
                op_d.push_back(e);
            end
            else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t")
            begin
                fail_run($sformatf("unknown record type '%c' in vtp_tests.txt", ch));
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // ====================
    // Drivers
    // ====================

    // All drivers start and end DRIVE_DELAY after a rising edge
    task automatic write_page(input vpn_t vpn, input ppn_t ppn, input logic valid);
        pt_wr_en = 1'b1;
        pt_wr_vpn = vpn;
        pt_wr_ppn = ppn;
        pt_wr_valid = valid;
        @(posedge clk);
        #DRIVE_DELAY;
        pt_wr_en = 1'b0;
    endtask

    task automatic issue_lookup(input tag_t tag, input vpn_t vpn, input ppn_t ppn,
                                input logic fault);
        int gap;
        logic accepted;
        gap = $unsigned($random(seed)) % (TB_GAP_MAX + 1);
        repeat (gap)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        assert (issue_cnt[tag] == return_cnt[tag])
        else fail_run($sformatf("test file reuses tag %0d while it is outstanding", tag));
        exp_ppn[tag] = ppn;
        exp_fault[tag] = fault;
        issue_cnt[tag]++;
        issued_total++;
        req_en = 1'b1;
        req_vpn = vpn;
        req_tag = tag;
        // req_rdy only moves at clock edges, so the falling edge shows the
        // value that the next rising edge will see
        do
        begin
            @(negedge clk);
            accepted = req_rdy;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        while (!accepted);
        req_en = 1'b0;
    endtask

    task automatic wait_for_drain();
        while (issued_total != returned_total)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // ====================
    // Response checks
    // ====================

    task automatic check_response();
        assert (issue_cnt[rsp_tag] != return_cnt[rsp_tag])
        else fail_run($sformatf("response arrived at %0t for tag %0d with no request outstanding",
                                $time, rsp_tag));
        assert (rsp_ppn == exp_ppn[rsp_tag])
        else fail_run($sformatf("ERROR %0t: rsp_ppn for tag %0d is %h, expected %h",
                                $time, rsp_tag, rsp_ppn, exp_ppn[rsp_tag]));
        assert (rsp_fault == exp_fault[rsp_tag])
        else fail_run($sformatf("ERROR %0t: rsp_fault for tag %0d is %b, expected %b",
                                $time, rsp_tag, rsp_fault, exp_fault[rsp_tag]));
        return_cnt[rsp_tag]++;
        returned_total++;
    endtask

    // Outputs are registered, so they are settled at the falling edge
    always @(negedge clk)
    begin
        if (!reset && rsp_valid)
            check_response();
    end

    initial
    begin
        #1;
        repeat (watchdog_cycles) @(posedge clk);
        fail_run($sformatf("watchdog expired after %0d cycles with %0d responses outstanding",
                           watchdog_cycles, issued_total - returned_total));
    end

    initial
    begin
        int i;
        reset = 1'b1;
        pt_wr_en = 1'b0;
        pt_wr_vpn = '0;
        pt_wr_ppn = '0;
        pt_wr_valid = 1'b0;
        req_en = 1'b0;
        req_vpn = '0;
        req_tag = '0;
        load_tests();
        watchdog_cycles = lookup_count * (WALK_CYCLES + 40) + 200;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        assert (req_rdy)
        else fail_run("req_rdy is low right after reset");
        for (i = 0; i < op_kind.size(); i++)
        begin
            case (op_kind[i])
                "W": write_page(vpn_t'(op_a[i]), ppn_t'(op_b[i]), op_c[i] != 0);
                "L": issue_lookup(tag_t'(op_a[i]), vpn_t'(op_b[i]), ppn_t'(op_c[i]),
                                  op_d[i] != 0);
                default: wait_for_drain();
            endcase
        end
        wait_for_drain();
        // Late or repeated responses would still show up here
        repeat (20) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vtp_tests.txt ====
# W vpn ppn valid : page-table write, all fields in hex
# L tag vpn ppn fault : lookup with its expected response, P ends a phase
# Setup and a cold miss
W 12 345 1
W 13 0a1 1
W 2c 777 0
W 5c abc 1
W 3c def 1
W 40 000 0
W 41 000 0
L 1 12 345 0
P
# Hit after fill mixed with misses and faults
L 1 12 345 0
L 2 13 0a1 0
L 3 12 345 0
L 4 2c 000 1
L 5 99 000 1
L 6 13 0a1 0
P
# Two VPNs sharing TLB index c evict each other
L 1 5c abc 0
L 2 3c def 0
P
L 3 5c abc 0
L 4 3c def 0
P
# Burst of sixteen, 40 and 41 were unmapped before
W 40 140 1
W 41 241 1
W 42 342 1
W 43 443 1
W 44 544 1
W 45 645 1
W 46 746 1
W 47 847 1
L 0 40 140 0
L 1 41 241 0
L 2 42 342 0
L 3 43 443 0
L 4 44 544 0
L 5 45 645 0
L 6 46 746 0
L 7 47 847 0
L 8 48 000 1
L 9 49 000 1
L a 4a 000 1
L b 4b 000 1
L c 4c 000 1
L d 4d 000 1
L e 4e 000 1
L f 4f 000 1
P

// ==== vtp.f ====
vtp_pkg.sv
vtp_ifs.sv
vtp_fifo.sv
vtp_walk_timer.sv
vtp_page_table.sv
vtp_walker.sv
vtp_tlb.sv
vtp_pipe.sv
vtp_top.sv
vtp_asserts.sv
vtp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = vtp_tb
FILELIST = vtp.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
